// File: hw/cache_pkg.sv
// geometry, address split and bus types shared by the cache RTL
// cmd_buf_depth must stay a power of two, since buffer pointers wrap naturally
`default_nettype none

package cache_pkg;

    // cache geometry
    localparam int sets        = 8;
    localparam int ways        = 2;
    localparam int block_words = 4;

    // address split, low two bits are the byte within a word
    localparam int index_bits  = $clog2(sets);
    localparam int offset_bits = $clog2(block_words);
    localparam int tag_bits    = 32 - index_bits - offset_bits - 2;

    localparam int way_bits    = $clog2(ways);
    localparam int age_bits    = $clog2(ways);

    // memory channel
    localparam int mem_credits   = 2;
    localparam int credit_bits   = $clog2(mem_credits + 1);
    localparam int cmd_buf_depth = 2;
    localparam int buf_ptr_bits  = $clog2(cmd_buf_depth);
    localparam int buf_cnt_bits  = $clog2(cmd_buf_depth + 1);

    typedef logic [block_words-1:0][31:0] block_t;

    typedef struct packed {
        logic        we;
        logic [31:0] addr;
        logic [3:0]  byte_mask;
        logic [31:0] wdata;
    } cpu_req_t;

    typedef enum logic {
        mem_read  = 1'b0,
        mem_write = 1'b1
    } mem_op_t;

    // addr is block aligned, data is zero for reads
    typedef struct packed {
        mem_op_t     op;
        logic [31:0] addr;
        block_t      data;
    } mem_cmd_t;

    typedef enum logic [2:0] {
        idle,
        lookup,
        writeback,
        fill_req,
        fill_wait
    } miss_state_t;

endpackage

`default_nettype wire

// File: hw/cache_tag_store.sv
// tag, state and data arrays of the set-associative cache, true LRU by age counters
// all lookups use the latched request; at most one of write_hit and fill per cycle
`timescale 1ns/1ps
`default_nettype none

module cache_tag_store (
    input  logic                clock,
    input  logic                reset,
    input  logic                lookup_en,
    input  cache_pkg::cpu_req_t req,
    input  logic                write_hit,
    input  logic                fill,
    input  cache_pkg::block_t   fill_data,
    output logic                hit,
    output logic                victim_dirty,
    output logic [31:0]         victim_addr,
    output cache_pkg::block_t   victim_data,
    output logic [31:0]         rdata
);
    import cache_pkg::*;

    logic [tag_bits-1:0]    tag_q   [sets][ways];
    block_t                 data_q  [sets][ways];
    logic [ways-1:0]        valid_q [sets];
    logic [ways-1:0]        dirty_q [sets];
    logic [age_bits-1:0]    age_q   [sets][ways];

    logic [tag_bits-1:0]    addr_tag;
    logic [index_bits-1:0]  addr_index;
    logic [offset_bits-1:0] addr_offset;

    logic [way_bits-1:0]    hit_way;
    logic [way_bits-1:0]    victim_way;
    logic [way_bits-1:0]    touch_way;
    logic                   touch;

    // byte lanes of wdata replace the addressed word where the mask is set
    function automatic block_t merge_word(
        input block_t                 blk,
        input logic [offset_bits-1:0] off,
        input logic [3:0]             mask,
        input logic [31:0]            wdata
    );
        block_t res;
        res = blk;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                res[off][8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign addr_tag    = req.addr[31 -: tag_bits];
    assign addr_index  = req.addr[offset_bits+2 +: index_bits];
    assign addr_offset = req.addr[2 +: offset_bits];

    // tag compare over the valid ways of the set
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < ways; w++) begin
            if (valid_q[addr_index][w] && tag_q[addr_index][w] == addr_tag) begin
                hit     = 1'b1;
                hit_way = way_bits'(w);
            end
        end
    end

    // oldest way is the victim
    always_comb begin
        victim_way = '0;
        for (int w = 0; w < ways; w++) begin
            if (age_q[addr_index][w] == age_bits'(ways - 1)) begin
                victim_way = way_bits'(w);
            end
        end
    end

    assign victim_dirty = valid_q[addr_index][victim_way] && dirty_q[addr_index][victim_way];
    assign victim_addr  = {tag_q[addr_index][victim_way], addr_index,
                           {offset_bits{1'b0}}, 2'b00};
    assign victim_data  = data_q[addr_index][victim_way];
    assign rdata        = data_q[addr_index][hit_way][addr_offset];

    // any hit or a fill makes the touched way the youngest
    assign touch     = (lookup_en && hit) || fill;
    assign touch_way = fill ? victim_way : hit_way;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            for (int s = 0; s < sets; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                for (int w = 0; w < ways; w++) begin
                    age_q[s][w] <= age_bits'(w);
                end
            end
        end else begin
            if (write_hit) begin
                dirty_q[addr_index][hit_way] <= 1'b1;
            end
            if (fill) begin
                valid_q[addr_index][victim_way] <= 1'b1;
                dirty_q[addr_index][victim_way] <= req.we;
            end
            if (touch) begin
                for (int w = 0; w < ways; w++) begin
                    if (way_bits'(w) == touch_way) begin
                        age_q[addr_index][w] <= '0;
                    end else if (age_q[addr_index][w] < age_q[addr_index][touch_way]) begin
                        age_q[addr_index][w] <= age_q[addr_index][w] + 1'b1;
                    end
                end
            end
        end
    end

    // tags and block data
    always_ff @(posedge clock) begin
        if (write_hit) begin
            data_q[addr_index][hit_way] <= merge_word(data_q[addr_index][hit_way],
                addr_offset, req.byte_mask, req.wdata);
        end
        if (fill) begin
            tag_q[addr_index][victim_way] <= addr_tag;
            if (req.we) begin
                data_q[addr_index][victim_way] <= merge_word(fill_data, addr_offset,
                    req.byte_mask, req.wdata);
            end else begin
                data_q[addr_index][victim_way] <= fill_data;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/cache_miss_fsm.sv
// blocking controller, one CPU request in flight and one outstanding fill at most
// a hit completes two cycles after acceptance, a miss waits for the fill response
`timescale 1ns/1ps
`default_nettype none

module cache_miss_fsm (
    input  logic                clock,
    input  logic                reset,
    input  logic                cpu_valid,
    input  cache_pkg::cpu_req_t cpu_req,
    input  logic                hit,
    input  logic                victim_dirty,
    input  logic [31:0]         victim_addr,
    input  cache_pkg::block_t   victim_data,
    input  logic                space,
    input  logic                mem_rsp_valid,
    input  cache_pkg::block_t   mem_rsp_data,
    output logic                cpu_ready,
    output logic                cpu_done,
    output logic                lookup_en,
    output cache_pkg::cpu_req_t req,
    output logic                write_hit,
    output logic                fill,
    output cache_pkg::block_t   fill_data,
    output logic                push,
    output cache_pkg::mem_cmd_t push_cmd
);
    import cache_pkg::*;

    miss_state_t state_q;
    miss_state_t state_d;
    logic        accept;
    logic [31:0] block_addr;

    assign accept     = cpu_valid && cpu_ready;
    assign block_addr = {req.addr[31:offset_bits+2], {offset_bits{1'b0}}, 2'b00};

    assign lookup_en  = (state_q == lookup);
    assign write_hit  = lookup_en && hit && req.we;

    always_comb begin
        state_d       = state_q;
        push          = 1'b0;
        push_cmd.op   = mem_read;
        push_cmd.addr = block_addr;
        push_cmd.data = '0;
        case (state_q)
            idle: begin
                if (accept) begin
                    state_d = lookup;
                end
            end
            lookup: begin
                if (hit) begin
                    state_d = idle;
                end else if (victim_dirty) begin
                    state_d = writeback;
                end else begin
                    state_d = fill_req;
                end
            end
            writeback: begin
                // dirty victim leaves before the fill is requested
                push          = space;
                push_cmd.op   = mem_write;
                push_cmd.addr = victim_addr;
                push_cmd.data = victim_data;
                if (space) begin
                    state_d = fill_req;
                end
            end
            fill_req: begin
                push = space;
                if (space) begin
                    state_d = fill_wait;
                end
            end
            fill_wait: begin
                if (mem_rsp_valid) begin
                    state_d = idle;
                end
            end
            default: state_d = idle;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q   <= idle;
            cpu_ready <= 1'b1;
            cpu_done  <= 1'b0;
            fill      <= 1'b0;
        end else begin
            state_q  <= state_d;
            // fill strobe lands in idle, done follows one cycle later
            fill     <= (state_q == fill_wait) && mem_rsp_valid;
            cpu_done <= (lookup_en && hit) || fill;
            if (accept) begin
                cpu_ready <= 1'b0;
            end else if (cpu_done) begin
                cpu_ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            req <= cpu_req;
        end
        if (mem_rsp_valid) begin
            fill_data <= mem_rsp_data;
        end
    end

endmodule

`default_nettype wire

// File: hw/mem_cmd_buffer.sv
// command FIFO in front of the credit-based memory channel
// memory takes every valid command, one credit spent per command issued
`timescale 1ns/1ps
`default_nettype none

module mem_cmd_buffer (
    input  logic                clock,
    input  logic                reset,
    input  logic                push,
    input  cache_pkg::mem_cmd_t push_cmd,
    input  logic                mem_credit,
    output logic                space,
    output logic                mem_cmd_valid,
    output cache_pkg::mem_cmd_t mem_cmd
);
    import cache_pkg::*;

    mem_cmd_t                fifo_q [cmd_buf_depth];
    logic [buf_ptr_bits-1:0] wr_ptr_q;
    logic [buf_ptr_bits-1:0] rd_ptr_q;
    logic [buf_cnt_bits-1:0] count_q;
    logic [credit_bits-1:0]  credits_q;
    logic                    push_ok;

    assign space   = (count_q != buf_cnt_bits'(cmd_buf_depth));
    assign push_ok = push && space;

    // head goes out whenever a credit is held
    assign mem_cmd_valid = (count_q != '0) && (credits_q != '0);
    assign mem_cmd       = fifo_q[rd_ptr_q];

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            count_q   <= '0;
            credits_q <= credit_bits'(mem_credits);
        end else begin
            if (push_ok) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (mem_cmd_valid) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q   <= count_q + buf_cnt_bits'(push_ok) - buf_cnt_bits'(mem_cmd_valid);
            // spend and return can coincide
            credits_q <= credits_q - credit_bits'(mem_cmd_valid) + credit_bits'(mem_credit);
        end
    end

    always_ff @(posedge clock) begin
        if (push_ok) begin
            fifo_q[wr_ptr_q] <= push_cmd;
        end
    end

endmodule

`default_nettype wire

// File: hw/cache_top.sv
// write-back, write-allocate data cache with a credit-based memory command port
`timescale 1ns/1ps
`default_nettype none

module cache_top (
    input  logic                clock,
    input  logic                reset,
    input  logic                cpu_valid,
    input  cache_pkg::cpu_req_t cpu_req,
    output logic                cpu_ready,
    output logic                cpu_done,
    output logic [31:0]         cpu_rdata,
    output logic                mem_cmd_valid,
    output cache_pkg::mem_cmd_t mem_cmd,
    input  logic                mem_credit,
    input  logic                mem_rsp_valid,
    input  cache_pkg::block_t   mem_rsp_data
);
    import cache_pkg::*;

    // controller to store
    logic        lookup_en;
    cpu_req_t    req;
    logic        write_hit;
    logic        fill;
    block_t      fill_data;

    // store to controller
    logic        hit;
    logic        victim_dirty;
    logic [31:0] victim_addr;
    block_t      victim_data;

    // controller to buffer
    logic        push;
    mem_cmd_t    push_cmd;
    logic        space;

    cache_tag_store store_i (
        .clock        (clock),
        .reset        (reset),
        .lookup_en    (lookup_en),
        .req          (req),
        .write_hit    (write_hit),
        .fill         (fill),
        .fill_data    (fill_data),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_addr  (victim_addr),
        .victim_data  (victim_data),
        .rdata        (cpu_rdata)
    );

    cache_miss_fsm fsm_i (
        .clock         (clock),
        .reset         (reset),
        .cpu_valid     (cpu_valid),
        .cpu_req       (cpu_req),
        .hit           (hit),
        .victim_dirty  (victim_dirty),
        .victim_addr   (victim_addr),
        .victim_data   (victim_data),
        .space         (space),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .cpu_ready     (cpu_ready),
        .cpu_done      (cpu_done),
        .lookup_en     (lookup_en),
        .req           (req),
        .write_hit     (write_hit),
        .fill          (fill),
        .fill_data     (fill_data),
        .push          (push),
        .push_cmd      (push_cmd)
    );

    mem_cmd_buffer buf_i (
        .clock         (clock),
        .reset         (reset),
        .push          (push),
        .push_cmd      (push_cmd),
        .mem_credit    (mem_credit),
        .space         (space),
        .mem_cmd_valid (mem_cmd_valid),
        .mem_cmd       (mem_cmd)
    );

endmodule

`default_nettype wire

// File: tests/mem_model.sv
// memory on the credit channel, one credit back per command after 0 to 3 idle cycles
// reads are answered in command order, untouched words hold an address pattern
`timescale 1ns/1ps
`default_nettype none

module mem_model (
    input  logic                clock,
    input  logic                reset,
    input  logic                mem_cmd_valid,
    input  cache_pkg::mem_cmd_t mem_cmd,
    output logic                mem_credit,
    output logic                mem_rsp_valid,
    output cache_pkg::block_t   mem_rsp_data,
    output int                  errors
);
    import cache_pkg::*;

    block_t      store [logic [31:0]];
    block_t      rsp_q [$];
    longint      credit_due [$];
    longint      now = 0;
    int          unreturned = 0;
    int          error_count = 0;
    logic [31:0] lfsr = 32'h9f7a_b82f;
    logic        credit_q = 1'b0;
    logic        rsp_valid_q = 1'b0;
    block_t      rsp_data_q = '0;

    assign mem_credit    = credit_q;
    assign mem_rsp_valid = rsp_valid_q;
    assign mem_rsp_data  = rsp_data_q;
    assign errors        = error_count;

    function automatic logic [1:0] random_delay();
        logic [1:0] v;
        v = '0;
        for (int i = 0; i < 2; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic block_t read_block(input logic [31:0] addr);
        block_t      blk;
        logic [31:0] a;
        if (store.exists(addr)) begin
            return store[addr];
        end
        for (int i = 0; i < block_words; i++) begin
            a      = addr + 32'(4 * i);
            blk[i] = {a[15:0], a[31:16]} ^ ~a ^ 32'h3c5a_96e1;
        end
        return blk;
    endfunction

    // commands and credit use are observed mid-cycle
    always @(negedge clock) begin
        if (reset) begin
            if (mem_cmd_valid) begin
                assert (unreturned < mem_credits) else begin
                    error_count++;
                    $display("memory received a command while the cache held no credit");
                end
                if (mem_cmd.op == mem_write) begin
                    store[mem_cmd.addr] = mem_cmd.data;
                end else begin
                    rsp_q.push_back(read_block(mem_cmd.addr));
                end
                credit_due.push_back(now + 1 + longint'(random_delay()));
            end
            unreturned = unreturned + int'(mem_cmd_valid) - int'(credit_q);
            assert (unreturned <= mem_credits) else begin
                error_count++;
                $display("more commands outstanding than the memory granted credits");
            end
        end
    end

    always @(posedge clock) begin
        now = now + 1;
        if (!reset) begin
            credit_q    <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            // at most one credit per cycle, the rest slip
            if (credit_due.size() > 0 && credit_due[0] <= now) begin
                credit_q <= 1'b1;
                void'(credit_due.pop_front());
            end else begin
                credit_q <= 1'b0;
            end
            if (rsp_q.size() > 0) begin
                rsp_valid_q <= 1'b1;
                rsp_data_q  <= rsp_q.pop_front();
            end else begin
                rsp_valid_q <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: tests/cache_tb.sv
// random word reads and masked writes over four tags per set, so dirty evictions occur
// the reference is a flat word memory plus a mirror of tags, dirty bits and ages
`timescale 1ns/1ps
`default_nettype none

module cache_tb;
    import cache_pkg::*;

    localparam int num_requests = 300;
    localparam int cycle_limit  = num_requests * 40;
    localparam logic [tag_bits-1:0] tag_base = 'h05a3c0;

    logic        clock = 1'b0;
    logic        reset;
    logic        cpu_valid;
    cpu_req_t    cpu_req;
    logic        cpu_ready;
    logic        cpu_done;
    logic [31:0] cpu_rdata;
    logic        mem_cmd_valid;
    mem_cmd_t    mem_cmd;
    logic        mem_credit;
    logic        mem_rsp_valid;
    block_t      mem_rsp_data;
    int          mem_errors;

    int          errors = 0;
    int          cycles = 0;
    logic [31:0] lfsr = 32'h9f7a_b82f;
    mem_cmd_t    seen_cmds [$];

    // reference state
    logic [31:0]         flat_mem [logic [31:0]];
    logic [tag_bits-1:0] tag_m    [sets][ways];
    logic                valid_m  [sets][ways];
    logic                dirty_m  [sets][ways];
    int                  age_m    [sets][ways];

    always #50 clock = ~clock;

    cache_top dut_i (
        .clock         (clock),
        .reset         (reset),
        .cpu_valid     (cpu_valid),
        .cpu_req       (cpu_req),
        .cpu_ready     (cpu_ready),
        .cpu_done      (cpu_done),
        .cpu_rdata     (cpu_rdata),
        .mem_cmd_valid (mem_cmd_valid),
        .mem_cmd       (mem_cmd),
        .mem_credit    (mem_credit),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data)
    );

    mem_model mem_i (
        .clock         (clock),
        .reset         (reset),
        .mem_cmd_valid (mem_cmd_valid),
        .mem_cmd       (mem_cmd),
        .mem_credit    (mem_credit),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .errors        (mem_errors)
    );

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // same pattern the memory holds before any writeback
    function automatic logic [31:0] read_word(input logic [31:0] a);
        if (flat_mem.exists(a)) begin
            return flat_mem[a];
        end
        return {a[15:0], a[31:16]} ^ ~a ^ 32'h3c5a_96e1;
    endfunction

    function automatic void merge_write(input cpu_req_t r);
        logic [31:0] a;
        logic [31:0] w;
        a = {r.addr[31:2], 2'b00};
        w = read_word(a);
        for (int b = 0; b < 4; b++) begin
            if (r.byte_mask[b]) begin
                w[8*b +: 8] = r.wdata[8*b +: 8];
            end
        end
        flat_mem[a] = w;
    endfunction

    function automatic void make_youngest(input int s, input int w);
        int old;
        old = age_m[s][w];
        for (int i = 0; i < ways; i++) begin
            if (age_m[s][i] < old) begin
                age_m[s][i]++;
            end
        end
        age_m[s][w] = 0;
    endfunction

    task automatic expect_equal(input string name, input logic [160:0] got,
                                input logic [160:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("ERROR: %s = %0h, expected %0h", name, got, exp);
        end
    endtask

    task automatic issue_request(input cpu_req_t r);
        logic [31:0]         blk_addr;
        logic [31:0]         vic_addr;
        logic [31:0]         exp_rdata;
        logic [tag_bits-1:0] tag;
        logic                was_hit;
        int                  set;
        int                  way;
        int                  n;
        int                  exp_cmds;
        mem_cmd_t            exp_wb;
        mem_cmd_t            got;

        blk_addr = {r.addr[31:offset_bits+2], {(offset_bits + 2){1'b0}}};
        tag      = r.addr[31 -: tag_bits];
        set      = int'(r.addr[offset_bits+2 +: index_bits]);
        way      = -1;
        for (int w = 0; w < ways; w++) begin
            if (valid_m[set][w] && tag_m[set][w] == tag) begin
                way = w;
            end
        end
        was_hit  = (way >= 0);
        exp_cmds = 0;
        exp_wb   = '0;
        if (!was_hit) begin
            // victim is the oldest way
            for (int w = 0; w < ways; w++) begin
                if (age_m[set][w] == ways - 1) begin
                    way = w;
                end
            end
            exp_cmds = 1;
            if (valid_m[set][way] && dirty_m[set][way]) begin
                vic_addr = {tag_m[set][way], r.addr[offset_bits+2 +: index_bits],
                            {(offset_bits + 2){1'b0}}};
                exp_wb.op   = mem_write;
                exp_wb.addr = vic_addr;
                for (int i = 0; i < block_words; i++) begin
                    exp_wb.data[i] = read_word(vic_addr + 32'(4 * i));
                end
                exp_cmds = 2;
            end
            tag_m[set][way]   = tag;
            valid_m[set][way] = 1'b1;
            dirty_m[set][way] = r.we;
        end else if (r.we) begin
            dirty_m[set][way] = 1'b1;
        end
        make_youngest(set, way);
        exp_rdata = read_word({r.addr[31:2], 2'b00});
        if (r.we) begin
            merge_write(r);
        end

        @(negedge clock);
        while (!cpu_ready) begin
            @(negedge clock);
        end
        @(posedge clock);
        cpu_valid <= 1'b1;
        cpu_req   <= r;
        // acceptance edge
        @(posedge clock);
        cpu_valid <= 1'b0;
        n = 0;
        do begin
            @(negedge clock);
            n++;
            assert (!cpu_ready) else begin
                errors++;
                $display("cpu_ready rose before cpu_done for address %h", r.addr);
            end
        end while (!cpu_done);

        if (was_hit) begin
            assert (n == 2) else begin
                errors++;
                $display("hit at %h took %0d cycles after acceptance instead of 2", r.addr, n);
            end
        end
        if (!r.we) begin
            expect_equal("cpu_rdata", cpu_rdata, exp_rdata);
        end
        assert (seen_cmds.size() == exp_cmds) else begin
            errors++;
            $display("request at %h sent %0d memory commands instead of %0d",
                     r.addr, seen_cmds.size(), exp_cmds);
        end
        if (seen_cmds.size() == exp_cmds && exp_cmds > 0) begin
            if (exp_cmds == 2) begin
                got = seen_cmds.pop_front();
                expect_equal("mem_cmd.op", got.op, exp_wb.op);
                expect_equal("mem_cmd.addr", got.addr, exp_wb.addr);
                expect_equal("mem_cmd.data", got.data, exp_wb.data);
            end
            got = seen_cmds.pop_front();
            expect_equal("mem_cmd.op", got.op, mem_read);
            expect_equal("mem_cmd.addr", got.addr, blk_addr);
            expect_equal("mem_cmd.data", got.data, 0);
        end
        seen_cmds.delete();
    endtask

    always @(negedge clock) begin
        if (reset && mem_cmd_valid) begin
            seen_cmds.push_back(mem_cmd);
        end
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("run stopped after %0d cycles, a request never completed", cycles);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        cpu_req_t r;

        reset     = 1'b0;
        cpu_valid = 1'b0;
        cpu_req   = '0;
        for (int s = 0; s < sets; s++) begin
            for (int w = 0; w < ways; w++) begin
                tag_m[s][w]   = '0;
                valid_m[s][w] = 1'b0;
                dirty_m[s][w] = 1'b0;
                age_m[s][w]   = w;
            end
        end
        repeat (10) @(posedge clock);
        reset <= 1'b1;
        @(negedge clock);
        expect_equal("cpu_ready", cpu_ready, 1);
        expect_equal("cpu_done", cpu_done, 0);
        expect_equal("mem_cmd_valid", mem_cmd_valid, 0);

        for (int i = 0; i < num_requests; i++) begin
            r.we        = 1'(random_bits(1));
            r.addr      = {tag_base + tag_bits'(random_bits(2)),
                           index_bits'(random_bits(index_bits)),
                           offset_bits'(random_bits(offset_bits)),
                           2'(random_bits(2))};
            r.byte_mask = 4'(random_bits(4));
            r.wdata     = random_bits(32);
            issue_request(r);
        end

        repeat (4) @(posedge clock);
        $display("errors: %0d total, %0d cache checks, %0d memory checks",
                 errors + mem_errors, errors, mem_errors);
        if (errors + mem_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
hw/cache_pkg.sv
hw/cache_tag_store.sv
hw/cache_miss_fsm.sv
hw/mem_cmd_buffer.sv
hw/cache_top.sv
tests/mem_model.sv
tests/cache_tb.sv

// File: Bender.yml
package:
  name: blocking_cache

sources:
  # package first, the RTL depends on it
  - hw/cache_pkg.sv
  - hw/cache_tag_store.sv
  - hw/cache_miss_fsm.sv
  - hw/mem_cmd_buffer.sv
  - hw/cache_top.sv
  - target: test
    files:
      - tests/mem_model.sv
      - tests/cache_tb.sv
